//--- uart_link_stimulus.txt
# data_byte bad_parity expected_pins, all hex, one receive frame per line
# bad_parity 1 sends the parity bit inverted, pins then keep the last good value
3c 1 00
5a 0 1a
c7 1 1a
c7 0 07
ff 0 3f
00 1 3f
81 1 3f
81 0 01
7e 0 3e
a5 1 3e
42 0 02
10 0 10
e9 1 10
96 0 16
40 0 00
2b 0 2b

//--- uart_link.f
+incdir+.
uart_pkg.sv
link_pkg.sv
uart_rx.sv
link_sequencer.sv
uart_tx.sv
uart_link_top.sv
uart_link_sva.sv
uart_link_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module uart_link_tb -f uart_link.f -o uart_link_sim \
    && ./obj_dir/uart_link_sim | tee /dev/stderr | grep -q "Result: PASSED" \
    && echo "run_sim: simulation passed" \
    || { echo "run_sim: simulation failed"; exit 1; }

//--- uart_link_tb.sv
`include "uart_link_consts.svh"
`timescale 1ns/1ps
`default_nettype none

module uart_link_tb
    import uart_pkg::*, link_pkg::*;
();

    logic         clk;
    logic         arst_n;
    logic         rx;
    logic         tx;
    pin_word_t    pins;
    status_leds_t leds;

    uart_byte_t   frame_data[$];   // Stimulus columns with one entry per frame
    logic         frame_bad[$];
    pin_word_t    frame_pins[$];

    int           errors = 0;
    int           checks = 0;
    int           since_rst;       // Clock edges since reset release
    int           cycle_limit = 4 * (`UART_FRAME_BITS + 2) * `UART_CLKS_PER_BIT
                                + `LINK_STARTUP_CYCLES;
    int           tx_frames = 0;
    uart_byte_t   tx_expect = '0;  // Next counter byte on tx
    pin_word_t    last_good = '0;  // Pins after the last good frame
    logic         reset_done = 1'b0;

    uart_link_top DUT (
        .clk    (clk),
        .arst_n (arst_n),
        .rx     (rx),
        .tx     (tx),
        .pins   (pins),
        .leds   (leds)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;  // 10 ns period

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            since_rst <= 0;
        else
            since_rst <= since_rst + 1;
    end

    task automatic flag_error(input string msg);
        errors++;
        $display("** Error @ %0d ns: %s", $time, msg);
    endtask

    // Quiet period followed by a steady blue light
    always @(negedge clk) begin
        if (reset_done && since_rst < `LINK_STARTUP_CYCLES) begin
            checks++;
            assert (tx === 1'b1 && leds === 3'b111)
            else flag_error($sformatf("start-up: tx %b leds %b", tx, leds));
        end else if (reset_done) begin
            checks++;
            assert (leds.blue === 1'b0) else flag_error("blue not lit after start-up");
        end
    end

    // Skips comment lines starting with #
    task automatic load_stimulus();
        int    fd;
        int    n;
        int    data_v;
        int    bad_v;
        int    pins_v;
        string line;
        fd = $fopen("uart_link_stimulus.txt", "r");
        if (fd == 0)
            return;
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && line.len() > 0 && line[0] != "#") begin
                if ($sscanf(line, "%h %h %h", data_v, bad_v, pins_v) == 3) begin
                    frame_data.push_back(uart_byte_t'(data_v));
                    frame_bad.push_back(bad_v != 0);
                    frame_pins.push_back(pin_word_t'(pins_v));
                end
            end
        end
        $fclose(fd);
    endtask

    // Start, data LSB first, parity, stop, then two idle bits
    task automatic send_frame(input uart_byte_t data, input logic bad);
        logic [`UART_FRAME_BITS-1:0] bits;
        logic                        par;
        par  = (^data) ^ bad;  // Even parity flipped on request
        bits = {1'b1, par, data, 1'b0};
        for (int i = 0; i < `UART_FRAME_BITS; i++) begin
            rx = bits[i];
            repeat (`UART_CLKS_PER_BIT) @(negedge clk);
        end
        rx = 1'b1;
        repeat (2 * `UART_CLKS_PER_BIT) @(negedge clk);
    endtask

    task automatic check_rx_result(input uart_byte_t data, input logic bad,
                                   input pin_word_t file_pins);
        if (!bad)
            last_good = data[5:0];  // Bad frames leave pins alone
        checks++;
        assert (file_pins == last_good)
        else flag_error($sformatf("stimulus file expects pins 0x%0h, rule gives 0x%0h",
                                  file_pins, last_good));
        checks++;
        assert (pins === last_good)
        else flag_error($sformatf("pins 0x%0h, expected 0x%0h after byte 0x%0h",
                                  pins, last_good, data));
        checks++;
        assert (leds.red === ~bad && leds.green === bad)  // Lit is 0
        else flag_error($sformatf("red %b green %b after bad=%b", leds.red, leds.green, bad));
    endtask

    task automatic check_tx_frame(input logic start, input uart_byte_t got,
                                  input logic par, input logic stop);
        checks++;
        assert (start === 1'b0 && stop === 1'b1)
        else flag_error($sformatf("tx framing: start %b stop %b", start, stop));
        checks++;
        assert (((^got) ^ par) === 1'b0)
        else flag_error($sformatf("tx parity %b wrong for 0x%0h", par, got));
        checks++;
        assert (got === tx_expect)
        else flag_error($sformatf("tx byte 0x%0h, expected 0x%0h", got, tx_expect));
        tx_expect = tx_expect + 8'd1;
        tx_frames++;
    endtask

    // Rebuilds tx frames from mid-bit samples
    initial begin : tx_monitor
        uart_byte_t got;
        logic       start;
        logic       par;
        logic       stop;
        wait (reset_done);
        forever begin
            @(negedge tx);
            repeat (`UART_CLKS_PER_BIT / 2) @(negedge clk);
            start = tx;
            for (int b = 0; b < 8; b++) begin
                repeat (`UART_CLKS_PER_BIT) @(negedge clk);
                got[b] = tx;
            end
            repeat (`UART_CLKS_PER_BIT) @(negedge clk);
            par = tx;
            repeat (`UART_CLKS_PER_BIT) @(negedge clk);
            stop = tx;
            check_tx_frame(start, got, par, stop);
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: stimulus not finished");
        $display("checks: %0d, errors: %0d", checks, errors);
        $display("Result: FAILED");
        $finish;
    end

    initial begin : main
        rx     = 1'b1;  // Idle line
        arst_n = 1'b1;
        load_stimulus();
        if (frame_data.size() == 0) begin
            errors++;
            $display("no frames could be read from uart_link_stimulus.txt");
        end
        cycle_limit = (frame_data.size() + 4) * (`UART_FRAME_BITS + 2) * `UART_CLKS_PER_BIT
                      + `LINK_STARTUP_CYCLES;
        #2 arst_n = 1'b0;  // Real falling edge on reset
        repeat (4) @(posedge clk);
        reset_done = 1'b1;  // Release follows on the next falling edge
        @(negedge clk);
        arst_n = 1'b1;
        while (leds.blue !== 1'b0)
            @(negedge clk);
        foreach (frame_data[i]) begin
            send_frame(frame_data[i], frame_bad[i]);
            check_rx_result(frame_data[i], frame_bad[i], frame_pins[i]);
        end
        checks++;
        assert (tx_frames >= frame_data.size())
        else flag_error($sformatf("only %0d tx frames decoded", tx_frames));
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- uart_link_sva.sv
`timescale 1ns/1ps
`default_nettype none

module uart_link_sva (
    input wire clk,
    input wire arst_n,
    input wire tx_start,  // Strobe from the sequencer
    input wire tx_busy,
    input wire tx
);

    // Busy only follows a start strobe
    busy_needs_start: assert property (
        @(posedge clk) disable iff (!arst_n)
        $rose(tx_busy) |-> $past(tx_start)
    ) else $error("tx_busy rose without a tx_start in the cycle before");

    // Idle line stays high
    idle_line_high: assert property (
        @(posedge clk) disable iff (!arst_n)
        !tx_busy |-> tx
    ) else $error("tx low while the transmitter is idle");

    // Sequencer waits for idle before a new strobe
    no_start_when_busy: assert property (
        @(posedge clk) disable iff (!arst_n)
        tx_start |-> !tx_busy
    ) else $error("tx_start issued while the transmitter is busy");

endmodule

// Transmitter holds the strobe, its busy level and the line
bind uart_tx uart_link_sva u_sva (
    .clk      (clk),
    .arst_n   (arst_n),
    .tx_start (tx_start),
    .tx_busy  (tx_busy),
    .tx       (tx)
);

`default_nettype wire

//--- uart_link_top.sv
`timescale 1ns/1ps
`default_nettype none

module uart_link_top import uart_pkg::*, link_pkg::*; (
    input  wire          clk,
    input  wire          arst_n,
    input  wire          rx,
    output logic         tx,
    output pin_word_t    pins,
    output status_leds_t leds
);

    rx_status_t rx_status;  // Receiver to sequencer
    uart_byte_t tx_data;
    logic       tx_start;
    logic       tx_busy;    // Transmitter back to sequencer

    // Input side
    uart_rx u_rx (
        .clk       (clk),
        .arst_n    (arst_n),
        .rx        (rx),
        .rx_status (rx_status)
    );

    // Counter loop and status lights
    link_sequencer u_seq (
        .clk       (clk),
        .arst_n    (arst_n),
        .rx_status (rx_status),
        .tx_busy   (tx_busy),
        .tx_data   (tx_data),
        .tx_start  (tx_start),
        .pins      (pins),
        .leds      (leds)
    );

    // Output side
    uart_tx u_tx (
        .clk       (clk),
        .arst_n    (arst_n),
        .tx_data   (tx_data),
        .tx_start  (tx_start),
        .tx        (tx),
        .tx_busy   (tx_busy)
    );

endmodule

`default_nettype wire

//--- uart_tx.sv
`include "uart_link_consts.svh"
`timescale 1ns/1ps
`default_nettype none

module uart_tx import uart_pkg::*; (
    input  wire        clk,
    input  wire        arst_n,
    input  uart_byte_t tx_data,
    input  wire        tx_start,  // Honored only while idle
    output logic       tx,        // Registered serial output
    output logic       tx_busy
);

    tx_state_t  state;
    baud_cnt_t  baud_cnt;
    bit_idx_t   bit_idx;
    uart_byte_t data_q;    // Byte being sent
    logic       parity_q;  // Even parity of data_q
    logic       bit_end;

    assign bit_end = (baud_cnt == baud_cnt_t'(`UART_CLKS_PER_BIT - 1));

    // Byte and parity latched on an accepted start
    always_ff @(posedge clk) begin
        if (tx_start && !tx_busy) begin
            data_q   <= tx_data;
            parity_q <= ^tx_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= TX_IDLE;
            baud_cnt <= '0;
            bit_idx  <= '0;
            tx       <= 1'b1;  // Idle line
            tx_busy  <= 1'b0;
        end else begin
            if (state != TX_IDLE)
                baud_cnt <= bit_end ? '0 : baud_cnt + 1'b1;
            case (state)
                TX_IDLE: begin
                    baud_cnt <= '0;
                    bit_idx  <= '0;
                    if (tx_start) begin
                        state   <= TX_START;
                        tx      <= 1'b0;  // Start bit
                        tx_busy <= 1'b1;
                    end
                end
                TX_START: begin
                    if (bit_end) begin
                        state <= TX_DATA;
                        tx    <= data_q[0];
                    end
                end
                TX_DATA: begin
                    if (bit_end) begin
                        if (bit_idx == 3'd7) begin
                            if (`UART_PARITY_EN != 0) begin
                                state <= TX_PARITY;
                                tx    <= parity_q;
                            end else begin
                                state <= TX_STOP;
                                tx    <= 1'b1;
                            end
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                            tx      <= data_q[bit_idx + 3'd1];  // Next bit up
                        end
                    end
                end
                TX_PARITY: begin
                    if (bit_end) begin
                        state <= TX_STOP;
                        tx    <= 1'b1;  // Stop bit
                    end
                end
                TX_STOP: begin
                    if (bit_end) begin
                        state   <= TX_IDLE;
                        tx_busy <= 1'b0;  // Frame complete
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- link_sequencer.sv
`include "uart_link_consts.svh"
`timescale 1ns/1ps
`default_nettype none

module link_sequencer import uart_pkg::*, link_pkg::*; (
    input  wire          clk,
    input  wire          arst_n,
    input  rx_status_t   rx_status,
    input  wire          tx_busy,
    output uart_byte_t   tx_data,   // Free-running byte counter
    output logic         tx_start,
    output pin_word_t    pins,
    output status_leds_t leds
);

    localparam logic LED_ON  = 1'b0;
    localparam logic LED_OFF = 1'b1;

    seq_state_t   state;
    startup_cnt_t startup_cnt;
    logic         startup_done;

    // Last cycle of the quiet period
    assign startup_done = (startup_cnt == startup_cnt_t'(`LINK_STARTUP_CYCLES - 1));

    // SEND lasts one cycle, so this is a single pulse
    assign tx_start = (state == SEND);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state       <= STARTUP;
            startup_cnt <= '0;
            tx_data     <= '0;
        end else begin
            case (state)
                STARTUP: begin
                    if (startup_done) begin
                        state   <= SEND;
                        tx_data <= '0;  // First byte out is zero
                    end else begin
                        startup_cnt <= startup_cnt + 1'b1;
                    end
                end
                SEND: state <= WAIT_BUSY;  // Transmitter idle here, start taken
                WAIT_BUSY: begin
                    if (tx_busy)
                        state <= WAIT_IDLE;
                end
                WAIT_IDLE: begin
                    if (!tx_busy) begin
                        state   <= SEND;
                        tx_data <= tx_data + 1'b1;  // Wraps at 255
                    end
                end
                default: state <= STARTUP;
            endcase
        end
    end

    // Receive capture and status lights
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pins <= '0;
            leds <= '{red: LED_OFF, green: LED_OFF, blue: LED_OFF};
        end else begin
            if (state == STARTUP && startup_done)
                leds.blue <= LED_ON;  // Link is up
            if (rx_status.done) begin
                if (rx_status.parity_error) begin
                    // Pins keep the last good byte
                    if (state != STARTUP) begin
                        leds.red   <= LED_ON;
                        leds.green <= LED_OFF;
                    end
                end else begin
                    pins <= rx_status.data[5:0];
                    if (state != STARTUP) begin  // Lights dark until start-up ends
                        leds.red   <= LED_OFF;
                        leds.green <= LED_ON;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- uart_rx.sv
`include "uart_link_consts.svh"
`timescale 1ns/1ps
`default_nettype none

module uart_rx import uart_pkg::*; (
    input  wire        clk,
    input  wire        arst_n,
    input  wire        rx,         // Asynchronous serial input
    output rx_status_t rx_status
);

    logic       rx_meta;   // First synchronizer stage
    logic       rx_sync;   // Safe to use from here on
    rx_state_t  state;
    baud_cnt_t  baud_cnt;
    bit_idx_t   bit_idx;
    uart_byte_t shift_q;   // Assembled byte
    logic       parity_q;  // Received parity bit
    logic       done_q;
    logic       perr_q;
    logic       half_end;
    logic       bit_end;
    logic       perr_calc;

    assign half_end = (baud_cnt == baud_cnt_t'(`UART_CLKS_PER_BIT / 2 - 1));
    assign bit_end  = (baud_cnt == baud_cnt_t'(`UART_CLKS_PER_BIT - 1));

    // Data plus parity bit must XOR to zero
    assign perr_calc = (`UART_PARITY_EN != 0) && (parity_q != ^shift_q);

    // Line idles high
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    // Payload path
    always_ff @(posedge clk) begin
        if (state == RX_DATA && bit_end)
            shift_q <= {rx_sync, shift_q[7:1]};  // LSB arrives first
        if (state == RX_PARITY && bit_end)
            parity_q <= rx_sync;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= RX_IDLE;
            baud_cnt <= '0;
            bit_idx  <= '0;
            done_q   <= 1'b0;
            perr_q   <= 1'b0;
        end else begin
            done_q <= 1'b0;  // Pulse by default low
            case (state)
                RX_IDLE: begin
                    baud_cnt <= '0;
                    bit_idx  <= '0;
                    if (!rx_sync)
                        state <= RX_START;  // Possible start edge
                end
                RX_START: begin
                    if (half_end) begin
                        baud_cnt <= '0;  // Re-centre on mid-bit
                        state    <= rx_sync ? RX_IDLE : RX_DATA;  // Glitch goes back
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (bit_end) begin
                        baud_cnt <= '0;
                        bit_idx  <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7)
                            state <= (`UART_PARITY_EN != 0) ? RX_PARITY : RX_STOP;
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                RX_PARITY: begin
                    if (bit_end) begin
                        baud_cnt <= '0;
                        state    <= RX_STOP;
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (bit_end) begin
                        baud_cnt <= '0;
                        state    <= RX_IDLE;
                        if (rx_sync) begin  // Low stop bit drops the frame
                            done_q <= 1'b1;
                            perr_q <= perr_calc;
                        end
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    assign rx_status = '{data: shift_q, done: done_q, parity_error: perr_q};

endmodule

`default_nettype wire

//--- link_pkg.sv
`default_nettype none

package link_pkg;

    typedef logic [31:0] startup_cnt_t;  // Wide enough for a full second at 48 MHz

    // Controller loop
    typedef enum logic [1:0] {
        STARTUP,    // Quiet period after reset
        SEND,       // Start strobe to the transmitter
        WAIT_BUSY,  // Wait for the frame to begin
        WAIT_IDLE   // Wait for the frame to finish
    } seq_state_t;

    typedef logic [5:0] pin_word_t;  // Low six bits of a received byte

    // Status lights, active low
    typedef struct packed {
        logic red;
        logic green;
        logic blue;
    } status_leds_t;

endpackage

`default_nettype wire

//--- uart_pkg.sv
`include "uart_link_consts.svh"
`default_nettype none

package uart_pkg;

    typedef logic [7:0] uart_byte_t;  // One data byte on the line

    // Bit timing counter, counts 0 .. CLKS_PER_BIT-1
    typedef logic [$clog2(`UART_CLKS_PER_BIT)-1:0] baud_cnt_t;

    typedef logic [2:0] bit_idx_t;  // Data bit position, LSB first

    // Transmit line states
    typedef enum logic [2:0] {
        TX_IDLE, TX_START, TX_DATA, TX_PARITY, TX_STOP
    } tx_state_t;

    // Receive line states
    typedef enum logic [2:0] {
        RX_IDLE, RX_START, RX_DATA, RX_PARITY, RX_STOP
    } rx_state_t;

    // Receiver result, data and parity_error qualified by done
    typedef struct packed {
        uart_byte_t data;
        logic       done;          // Single-cycle pulse
        logic       parity_error;  // Even parity mismatch
    } rx_status_t;

endpackage

`default_nettype wire

//--- uart_link_consts.svh
`ifndef UART_LINK_CONSTS_SVH
`define UART_LINK_CONSTS_SVH

// Serial bit timing
// 8 clocks per bit keeps simulation short
// 48 gives 1 Mbaud from a 48 MHz clock
`define UART_CLKS_PER_BIT 8

// Even parity bit after the data bits when set
`define UART_PARITY_EN 1

// Start, 8 data, parity, stop
`define UART_FRAME_BITS 11

// Quiet period after reset before the link starts
// Around 48000000 for one second on hardware
`define LINK_STARTUP_CYCLES 64

`endif
